// File: hdl/inversePkg.sv
package inversePkg;

    ////////////////////////////////////////////////////////////////////////
    // Matrix geometry
    ////////////////////////////////////////////////////////////////////////

    // Rows and pivot columns of the square part
    localparam int matDim = 5;

    // Left half A, right half the identity
    localparam int augCols = 10;

    localparam int wordWidth = 32;

    ////////////////////////////////////////////////////////////////////////
    // Element and address types
    ////////////////////////////////////////////////////////////////////////

    // Arithmetic wraps at the word width
    typedef logic signed [wordWidth-1:0] matWord_t;

    typedef logic [2:0] rowIdx_t;
    typedef logic [3:0] colIdx_t;

endpackage

// File: hdl/matrixPortIf.sv
`timescale 1ns/1ps

interface matrixPortIf;
    import inversePkg::*;

    logic req;
    logic we;
    rowIdx_t row;
    colIdx_t col;
    matWord_t wdata;

    // Returned by the arbiter
    logic gnt;
    matWord_t rdata;
    logic rvalid;

    modport requester
    (
        output req,
        output we,
        output row,
        output col,
        output wdata,
        input  gnt,
        input  rdata,
        input  rvalid
    );

    modport arbiter
    (
        input  req,
        input  we,
        input  row,
        input  col,
        input  wdata,
        output gnt,
        output rdata,
        output rvalid
    );

endinterface

// File: hdl/matrixStore.sv
`timescale 1ns/1ps

module matrixStore
(
    input  logic clk,
    input  logic we,
    input  inversePkg::rowIdx_t row,
    input  inversePkg::colIdx_t col,
    input  inversePkg::matWord_t wdata,
    output inversePkg::matWord_t rdata
);
    import inversePkg::*;

    // Row-major augmented matrix
    matWord_t mem [matDim][augCols];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[row][col] <= wdata;
        end
        // Registered read, data one cycle after the address
        rdata <= mem[row][col];
    end

    // Every requester must keep its address inside the matrix
    addrInRange: assert property (
        @(posedge clk) (row < matDim) && (col < augCols)
    );

endmodule

// File: hdl/matrixArbiter.sv
`timescale 1ns/1ps

module matrixArbiter
(
    input  logic clk,
    input  logic arstN,
    matrixPortIf.arbiter pivotPort,
    matrixPortIf.arbiter elimPort,
    matrixPortIf.arbiter hostPort,
    output logic we,
    output inversePkg::rowIdx_t row,
    output inversePkg::colIdx_t col,
    output inversePkg::matWord_t wdata,
    input  inversePkg::matWord_t rdata
);
    logic [2:0] gnt;
    logic [2:0] rdOwner;

    // Fixed priority: pivot search, then elimination, then host
    assign gnt[0] = pivotPort.req;
    assign gnt[1] = elimPort.req && !pivotPort.req;
    assign gnt[2] = hostPort.req && !pivotPort.req && !elimPort.req;

    assign pivotPort.gnt = gnt[0];
    assign elimPort.gnt = gnt[1];
    assign hostPort.gnt = gnt[2];

    always_comb
    begin
        we = 1'b0;
        row = '0;
        col = '0;
        wdata = '0;
        if (gnt[0])
        begin
            we = pivotPort.we;
            row = pivotPort.row;
            col = pivotPort.col;
            wdata = pivotPort.wdata;
        end
        else if (gnt[1])
        begin
            we = elimPort.we;
            row = elimPort.row;
            col = elimPort.col;
            wdata = elimPort.wdata;
        end
        else if (gnt[2])
        begin
            we = hostPort.we;
            row = hostPort.row;
            col = hostPort.col;
            wdata = hostPort.wdata;
        end
    end

    // Who gets the read data next cycle
    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            rdOwner <= '0;
        end
        else
        begin
            rdOwner[0] <= gnt[0] && !pivotPort.we;
            rdOwner[1] <= gnt[1] && !elimPort.we;
            rdOwner[2] <= gnt[2] && !hostPort.we;
        end
    end

    assign pivotPort.rvalid = rdOwner[0];
    assign elimPort.rvalid = rdOwner[1];
    assign hostPort.rvalid = rdOwner[2];
    assign pivotPort.rdata = rdOwner[0] ? rdata : '0;
    assign elimPort.rdata = rdOwner[1] ? rdata : '0;
    assign hostPort.rdata = rdOwner[2] ? rdata : '0;

    // A starved host keeps its request and access until granted
    hostHolds: assert property (
        @(posedge clk) disable iff (!arstN)
        hostPort.req && !hostPort.gnt |=>
            hostPort.req && $stable(hostPort.we) && $stable(hostPort.row)
            && $stable(hostPort.col) && $stable(hostPort.wdata)
    );

    // The sequencer runs the two datapath units strictly in turn
    unitsExclusive: assert property (
        @(posedge clk) disable iff (!arstN) !(pivotPort.req && elimPort.req)
    );

endmodule

// File: hdl/pivotSearch.sv
`timescale 1ns/1ps

module pivotSearch
(
    input  logic clk,
    input  logic arstN,
    input  logic go,
    input  inversePkg::colIdx_t column,
    matrixPortIf.requester port,
    output logic done,
    output logic found
);
    import inversePkg::*;

    typedef enum logic [3:0]
    {
        pIdle, pScan, pWtScan, pRdK, pWtK, pRdR, pWtR, pWrK, pWrR
    } pivotState_t;

    pivotState_t state;
    colIdx_t colK;
    colIdx_t swapCol;
    rowIdx_t rowCur;
    rowIdx_t kRow;
    matWord_t wordK;
    matWord_t wordR;

    assign kRow = rowIdx_t'(colK);

    assign port.req = state inside {pScan, pRdK, pRdR, pWrK, pWrR};
    assign port.we = state inside {pWrK, pWrR};
    assign port.row = (state inside {pRdK, pWrK}) ? kRow : rowCur;
    assign port.col = (state == pScan) ? colK : swapCol;
    // Cross write, each row gets the other's word
    assign port.wdata = (state == pWrK) ? wordR : wordK;

    always_ff @(posedge clk)
    begin
        if (port.rvalid && state == pWtK)
        begin
            wordK <= port.rdata;
        end
        if (port.rvalid && state == pWtR)
        begin
            wordR <= port.rdata;
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= pIdle;
            colK <= '0;
            swapCol <= '0;
            rowCur <= '0;
            done <= 1'b0;
            found <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                pIdle:
                    if (go)
                    begin
                        colK <= column;
                        rowCur <= rowIdx_t'(column);
                        state <= pScan;
                    end
                pScan:
                    if (port.gnt)
                        state <= pWtScan;
                pWtScan:
                    if (port.rvalid)
                    begin
                        if (port.rdata != '0 && rowCur == kRow)
                        begin
                            done <= 1'b1;
                            found <= 1'b1;
                            state <= pIdle;
                        end
                        else if (port.rdata != '0)
                        begin
                            swapCol <= '0;
                            state <= pRdK;
                        end
                        else if (rowCur == rowIdx_t'(matDim - 1))
                        begin
                            // Whole column zero from row k down
                            done <= 1'b1;
                            found <= 1'b0;
                            state <= pIdle;
                        end
                        else
                        begin
                            rowCur <= rowCur + 1'b1;
                            state <= pScan;
                        end
                    end
                pRdK:
                    if (port.gnt)
                        state <= pWtK;
                pWtK:
                    if (port.rvalid)
                        state <= pRdR;
                pRdR:
                    if (port.gnt)
                        state <= pWtR;
                pWtR:
                    if (port.rvalid)
                        state <= pWrK;
                pWrK:
                    if (port.gnt)
                        state <= pWrR;
                pWrR:
                    if (port.gnt && swapCol == colIdx_t'(augCols - 1))
                    begin
                        done <= 1'b1;
                        found <= 1'b1;
                        state <= pIdle;
                    end
                    else if (port.gnt)
                    begin
                        swapCol <= swapCol + 1'b1;
                        state <= pRdK;
                    end
                default:
                    state <= pIdle;
            endcase
        end
    end

endmodule

// File: hdl/rowEliminate.sv
`timescale 1ns/1ps

module rowEliminate
(
    input  logic clk,
    input  logic arstN,
    input  logic go,
    input  inversePkg::colIdx_t column,
    matrixPortIf.requester port,
    output logic done
);
    import inversePkg::*;

    typedef enum logic [3:0]
    {
        eIdle, eRow, eStep, eRdPivot, eWtPivot, eRdFactor, eWtFactor,
        eRdK, eWtK, eRdI, eWtI, eWrI
    } elimState_t;

    elimState_t state;
    colIdx_t colK;
    colIdx_t colCur;
    rowIdx_t rowCur;
    rowIdx_t kRow;
    matWord_t pivot;
    matWord_t factor;
    matWord_t wordK;
    matWord_t wordI;

    assign kRow = rowIdx_t'(colK);

    assign port.req = state inside {eRdPivot, eRdFactor, eRdK, eRdI, eWrI};
    assign port.we = (state == eWrI);
    assign port.row = (state inside {eRdPivot, eRdK}) ? kRow : rowCur;
    assign port.col = (state inside {eRdPivot, eRdFactor}) ? colK : colCur;
    // a[i][j]*a[k][k] - a[k][j]*a[i][k], truncated to the word
    assign port.wdata = wordI * pivot - wordK * factor;

    // Pivot and factor stay fixed for the whole row
    always_ff @(posedge clk)
    begin
        if (port.rvalid)
        begin
            case (state)
                eWtPivot: pivot <= port.rdata;
                eWtFactor: factor <= port.rdata;
                eWtK: wordK <= port.rdata;
                eWtI: wordI <= port.rdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= eIdle;
            colK <= '0;
            colCur <= '0;
            rowCur <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                eIdle:
                    if (go)
                    begin
                        colK <= column;
                        rowCur <= '0;
                        state <= eRow;
                    end
                eRow:
                    state <= (rowCur == kRow) ? eStep : eRdPivot;
                eStep:
                    if (rowCur == rowIdx_t'(matDim - 1))
                    begin
                        done <= 1'b1;
                        state <= eIdle;
                    end
                    else
                    begin
                        rowCur <= rowCur + 1'b1;
                        state <= eRow;
                    end
                eRdPivot:
                    if (port.gnt)
                        state <= eWtPivot;
                eWtPivot:
                    if (port.rvalid)
                        state <= eRdFactor;
                eRdFactor:
                    if (port.gnt)
                        state <= eWtFactor;
                eWtFactor:
                    if (port.rvalid)
                    begin
                        colCur <= '0;
                        // Nothing to clear in this row
                        state <= (port.rdata == '0) ? eStep : eRdK;
                    end
                eRdK:
                    if (port.gnt)
                        state <= eWtK;
                eWtK:
                    if (port.rvalid)
                        state <= eRdI;
                eRdI:
                    if (port.gnt)
                        state <= eWtI;
                eWtI:
                    if (port.rvalid)
                        state <= eWrI;
                eWrI:
                    if (port.gnt && colCur == colIdx_t'(augCols - 1))
                        state <= eStep;
                    else if (port.gnt)
                    begin
                        colCur <= colCur + 1'b1;
                        state <= eRdK;
                    end
                default:
                    state <= eIdle;
            endcase
        end
    end

endmodule

// File: hdl/eliminationSequencer.sv
`timescale 1ns/1ps

module eliminationSequencer
(
    input  logic clk,
    input  logic arstN,
    input  logic start,
    output logic pivotGo,
    input  logic pivotDone,
    input  logic pivotFound,
    output logic elimGo,
    input  logic elimDone,
    output inversePkg::colIdx_t column,
    output logic busy,
    output logic done,
    output logic singular
);
    import inversePkg::*;

    typedef enum logic [1:0] {sIdle, sPivot, sElim} seqState_t;

    seqState_t state;

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= sIdle;
            column <= '0;
            pivotGo <= 1'b0;
            elimGo <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            singular <= 1'b0;
        end
        else
        begin
            pivotGo <= 1'b0;
            elimGo <= 1'b0;
            done <= 1'b0;
            case (state)
                sIdle:
                    if (start)
                    begin
                        column <= '0;
                        pivotGo <= 1'b1;
                        busy <= 1'b1;
                        singular <= 1'b0;
                        state <= sPivot;
                    end
                sPivot:
                    if (pivotDone && !pivotFound)
                    begin
                        // No pivot in this column, stop here
                        busy <= 1'b0;
                        done <= 1'b1;
                        singular <= 1'b1;
                        state <= sIdle;
                    end
                    else if (pivotDone)
                    begin
                        elimGo <= 1'b1;
                        state <= sElim;
                    end
                sElim:
                    if (elimDone && column == colIdx_t'(matDim - 1))
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                        state <= sIdle;
                    end
                    else if (elimDone)
                    begin
                        column <= column + 1'b1;
                        pivotGo <= 1'b1;
                        state <= sPivot;
                    end
                default:
                    state <= sIdle;
            endcase
        end
    end

    // Unit done pulses only arrive in their own phase
    doneInPhase: assert property (
        @(posedge clk) disable iff (!arstN)
        (!pivotDone || state == sPivot) && (!elimDone || state == sElim)
    );

endmodule

// File: hdl/inverseTop.sv
`timescale 1ns/1ps

module inverseTop
(
    input  logic clk,
    input  logic arstN,
    input  logic start,
    output logic busy,
    output logic done,
    output logic singular,
    input  logic hostReq,
    input  logic hostWe,
    input  inversePkg::rowIdx_t hostRow,
    input  inversePkg::colIdx_t hostCol,
    input  inversePkg::matWord_t hostWdata,
    output logic hostGnt,
    output inversePkg::matWord_t hostRdata,
    output logic hostRvalid
);
    import inversePkg::*;

    logic storeWe;
    rowIdx_t storeRow;
    colIdx_t storeCol;
    matWord_t storeWdata;
    matWord_t storeRdata;
    logic pivotGo;
    logic pivotDone;
    logic pivotFound;
    logic elimGo;
    logic elimDone;
    colIdx_t column;

    matrixPortIf pivotIf ();
    matrixPortIf elimIf ();
    matrixPortIf hostIf ();

    ////////////////////////////////////////////////////////////////////////
    // Host side of the store port
    ////////////////////////////////////////////////////////////////////////

    assign hostIf.req = hostReq;
    assign hostIf.we = hostWe;
    assign hostIf.row = hostRow;
    assign hostIf.col = hostCol;
    assign hostIf.wdata = hostWdata;
    assign hostGnt = hostIf.gnt;
    assign hostRdata = hostIf.rdata;
    assign hostRvalid = hostIf.rvalid;

    ////////////////////////////////////////////////////////////////////////
    // Units
    ////////////////////////////////////////////////////////////////////////

    matrixStore matrixStore_i
    (
        .clk(clk),
        .we(storeWe),
        .row(storeRow),
        .col(storeCol),
        .wdata(storeWdata),
        .rdata(storeRdata)
    );

    matrixArbiter matrixArbiter_i
    (
        .clk(clk),
        .arstN(arstN),
        .pivotPort(pivotIf.arbiter),
        .elimPort(elimIf.arbiter),
        .hostPort(hostIf.arbiter),
        .we(storeWe),
        .row(storeRow),
        .col(storeCol),
        .wdata(storeWdata),
        .rdata(storeRdata)
    );

    pivotSearch pivotSearch_i
    (
        .clk(clk),
        .arstN(arstN),
        .go(pivotGo),
        .column(column),
        .port(pivotIf.requester),
        .done(pivotDone),
        .found(pivotFound)
    );

    rowEliminate rowEliminate_i
    (
        .clk(clk),
        .arstN(arstN),
        .go(elimGo),
        .column(column),
        .port(elimIf.requester),
        .done(elimDone)
    );

    eliminationSequencer eliminationSequencer_i
    (
        .clk(clk),
        .arstN(arstN),
        .start(start),
        .pivotGo(pivotGo),
        .pivotDone(pivotDone),
        .pivotFound(pivotFound),
        .elimGo(elimGo),
        .elimDone(elimDone),
        .column(column),
        .busy(busy),
        .done(done),
        .singular(singular)
    );

endmodule

// File: testbench/inverseTb.sv
`timescale 1ns/1ps

module inverseTb;
    import inversePkg::*;

    localparam int clkPeriod = 40;
    localparam int numRuns = 5;
    localparam int watchdogCycles = 4000 * numRuns;

    logic clk;
    logic arstN;
    logic start;
    logic busy;
    logic done;
    logic singular;
    logic hostReq;
    logic hostWe;
    rowIdx_t hostRow;
    colIdx_t hostCol;
    matWord_t hostWdata;
    logic hostGnt;
    matWord_t hostRdata;
    logic hostRvalid;

    logic [15:0] lfsr = 16'd70;
    matWord_t model [matDim][augCols];
    logic modelSing;

    inverseTop inverseTop_i
    (
        .clk(clk),
        .arstN(arstN),
        .start(start),
        .busy(busy),
        .done(done),
        .singular(singular),
        .hostReq(hostReq),
        .hostWe(hostWe),
        .hostRow(hostRow),
        .hostCol(hostCol),
        .hostWdata(hostWdata),
        .hostGnt(hostGnt),
        .hostRdata(hostRdata),
        .hostRvalid(hostRvalid)
    );

    always #(clkPeriod / 2) clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input matWord_t expected, input matWord_t actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("FAIL at time %0t: %s expected %0d, got %0d",
                $time, name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            abortRun($sformatf("FAIL at time %0t: %s expected %b, got %b",
                $time, name, expected, actual));
        end
    endtask

    initial
    begin
        #(watchdogCycles * clkPeriod);
        abortRun("Watchdog expired before the tests finished");
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers
    //////////////////////////////////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextRandomBit();
        logic outBit;
        outBit = lfsr[15];
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        return outBit;
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++)
        begin
            v = {v[30:0], nextRandomBit()};
        end
        return v;
    endfunction

    // Entries from -3 to 3
    function automatic matWord_t randomEntry();
        int v;
        v = int'(randomBits(3));
        return matWord_t'((v % 7) - 3);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Host port and reference model
    //////////////////////////////////////////////////////////////////////

    // Called at a falling edge, returns at one
    task automatic hostWrite(input int r, input int c, input matWord_t d);
        logic granted;
        granted = 1'b0;
        hostReq = 1'b1;
        hostWe = 1'b1;
        hostRow = rowIdx_t'(r);
        hostCol = colIdx_t'(c);
        hostWdata = d;
        while (!granted)
        begin
            #1;
            granted = hostGnt;
            @(negedge clk);
        end
        hostReq = 1'b0;
        hostWe = 1'b0;
    endtask

    task automatic hostRead(input int r, input int c, output matWord_t d);
        logic granted;
        granted = 1'b0;
        hostReq = 1'b1;
        hostWe = 1'b0;
        hostRow = rowIdx_t'(r);
        hostCol = colIdx_t'(c);
        while (!granted)
        begin
            #1;
            granted = hostGnt;
            @(negedge clk);
        end
        hostReq = 1'b0;
        if (hostRvalid !== 1'b1)
        begin
            abortRun("Read data valid did not follow a granted host read");
        end
        d = hostRdata;
    endtask

    task automatic loadModel();
        for (int r = 0; r < matDim; r++)
        begin
            for (int c = 0; c < augCols; c++)
            begin
                hostWrite(r, c, model[r][c]);
            end
        end
    endtask

    task automatic compareStore();
        matWord_t got;
        for (int r = 0; r < matDim; r++)
        begin
            for (int c = 0; c < augCols; c++)
            begin
                hostRead(r, c, got);
                checkWord($sformatf("a[%0d][%0d]", r, c), model[r][c], got);
            end
        end
    endtask

    // Random left half, identity on the right
    task automatic randomMatrix();
        for (int r = 0; r < matDim; r++)
        begin
            for (int c = 0; c < augCols; c++)
            begin
                model[r][c] = (c < matDim) ? randomEntry() : matWord_t'(c - matDim == r);
            end
        end
    endtask

    task automatic runModel(output logic sing);
        int p;
        matWord_t tmp;
        matWord_t pivot;
        matWord_t factor;
        sing = 1'b0;
        for (int k = 0; k < matDim; k++)
        begin
            p = -1;
            for (int r = matDim - 1; r >= k; r--)
            begin
                if (model[r][k] != 0)
                    p = r;
            end
            if (p < 0)
            begin
                sing = 1'b1;
                return;
            end
            for (int j = 0; j < augCols && p != k; j++)
            begin
                tmp = model[k][j];
                model[k][j] = model[p][j];
                model[p][j] = tmp;
            end
            for (int i = 0; i < matDim; i++)
            begin
                pivot = model[k][k];
                factor = model[i][k];
                for (int j = 0; j < augCols && i != k && factor != 0; j++)
                begin
                    model[i][j] = model[i][j] * pivot - model[k][j] * factor;
                end
            end
        end
    endtask

    // Pulse start, wait for done and compare against the model
    task automatic runAndCompare();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        checkFlag("busy", 1'b1, busy);
        checkFlag("singular", 1'b0, singular);
        runModel(modelSing);
        while (!done)
        begin
            @(negedge clk);
        end
        checkFlag("busy", 1'b0, busy);
        checkFlag("singular", modelSing, singular);
        @(negedge clk);
        compareStore();
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int zeroCol;
        int e;
        clk = 1'b0;
        arstN = 1'b0;
        start = 1'b0;
        hostReq = 1'b0;
        hostWe = 1'b0;
        hostRow = '0;
        hostCol = '0;
        hostWdata = '0;
        repeat (5) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);
        checkFlag("busy", 1'b0, busy);
        checkFlag("done", 1'b0, done);
        checkFlag("singular", 1'b0, singular);
        checkFlag("hostGnt", 1'b0, hostGnt);
        checkFlag("hostRvalid", 1'b0, hostRvalid);

        // Plain store access with full-width words
        for (int r = 0; r < matDim; r++)
        begin
            for (int c = 0; c < augCols; c++)
            begin
                model[r][c] = matWord_t'(randomBits(32));
            end
        end
        loadModel();
        compareStore();

        randomMatrix();
        loadModel();
        runAndCompare();

        // Anti-triangular, so column 0 needs a swap
        randomMatrix();
        for (int r = 0; r < matDim; r++)
        begin
            for (int c = 0; c < matDim - 1 - r; c++)
            begin
                model[r][c] = '0;
            end
            e = 1 + int'(randomBits(2)) % 3;
            model[r][matDim - 1 - r] = randomBits(1) ? matWord_t'(-e) : matWord_t'(e);
        end
        loadModel();
        runAndCompare();

        randomMatrix();
        zeroCol = int'(randomBits(3)) % matDim;
        for (int r = 0; r < matDim; r++)
        begin
            model[r][zeroCol] = '0;
        end
        loadModel();
        runAndCompare();
        checkFlag("singular", 1'b1, singular);

        // Restart after a singular run
        randomMatrix();
        loadModel();
        runAndCompare();

        $display("Everything OK");
        $finish;
    end

endmodule

// File: build.f
hdl/inversePkg.sv
hdl/matrixPortIf.sv
hdl/matrixStore.sv
hdl/matrixArbiter.sv
hdl/pivotSearch.sv
hdl/rowEliminate.sv
hdl/eliminationSequencer.sv
hdl/inverseTop.sv
testbench/inverseTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the inverseTb simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module inverseTb \
    -f build.f \
    -o inverseSim

./obj_dir/inverseSim
